// File: hdl/decode_config.svh
// Build-time sizes for the decode stage
// Machine word width, architectural register count and the number of
// pipeline slots during which a jump-and-link blocks writeback writes
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// Width of one machine word and of every register
`define DATA_WIDTH 16

// Eight general registers, register 7 doubles as the link register
`define REG_COUNT 8

// A jump-and-link owns the write port through its EX, MEM and WB slots
`define LINK_DEPTH 3

`endif

// File: hdl/isaPkg.sv
// Instruction-set types shared by the decode stage
// Word and register address vectors, opcode field, branch condition enum
// and the fixed opcodes and register numbers the decoder relies on
`include "decode_config.svh"

package isaPkg;

   // One register or instruction value
   typedef logic [`DATA_WIDTH-1:0] word_t;

   // Register number, wide enough to name every architectural register
   typedef logic [$clog2(`REG_COUNT)-1:0] regAddr_t;

   // Major opcode field taken from instruction bits 15 to 11
   typedef logic [4:0] opcode_t;

   // Branch condition held in the low two opcode bits (instruction 12 to 11)
   typedef enum logic [1:0] {
      BEQZ = 2'b00,
      BNEZ = 2'b01,
      BLTZ = 2'b10,
      BGEZ = 2'b11
   } branchCond_t;

   // Jump-and-link opcodes, the immediate and the register form
   localparam opcode_t OP_JAL  = 5'b00110;
   localparam opcode_t OP_JALR = 5'b00111;

   // All four conditional branches share the upper opcode bits 011
   localparam logic [2:0] OP_BRANCH_HI = 3'b011;

   // Return addresses always land in the last register
   localparam regAddr_t LINK_REG = regAddr_t'(`REG_COUNT - 1);

endpackage

// File: hdl/decodePkg.sv
// Types used only inside the decode stage
// Link shadow vector and the decoded instruction class enum
`include "decode_config.svh"

package decodePkg;

   // One bit per downstream slot (EX, MEM, WB) holding a jump-and-link
   // Bit 0 is the youngest slot, the top bit is writeback
   typedef logic [`LINK_DEPTH-1:0] linkShadow_t;

   // Coarse class of the instruction sitting in decode
   // OTHER covers everything the stage does not treat specially
   typedef enum logic [1:0] {
      OTHER  = 2'd0,
      BRANCH = 2'd1,
      JAL    = 2'd2,
      JALR   = 2'd3
   } instrClass_t;

endpackage

// File: hdl/regPortIf.sv
// Register file port bundle
// Two read ports and one write port, with modports for the register file,
// the decode control block and the write data selector
`timescale 1ns/10ps

interface regPortIf import isaPkg::*; ();

   // Read side, addresses from control and data back from the file
   regAddr_t readAddr1;
   regAddr_t readAddr2;
   word_t    readData1;
   word_t    readData2;

   // Write side, address and strobe from control and data from the selector
   logic     writeEn;
   regAddr_t writeAddr;
   word_t    writeData;

   modport file (
      input  readAddr1, readAddr2, writeEn, writeAddr, writeData,
      output readData1, readData2
   );

   modport ctrl (
      output readAddr1, readAddr2, writeEn, writeAddr
   );

   modport data (
      output writeData
   );

endinterface

// File: hdl/decodeControl.sv
// Decode control block
// Opcode classification, source register selection, the link shadow that
// tracks jump-and-link instructions downstream, and write port arbitration
`timescale 1ns/10ps
`include "decode_config.svh"

module decodeControl
   import isaPkg::*;
   import decodePkg::*;
(
   input  logic        clk,
   input  logic        arstN,
   input  word_t       instr,
   input  logic        wbEn,
   input  regAddr_t    wbAddr,
   regPortIf.ctrl      regs,
   output logic        isBranch,
   output logic        isLink,
   output branchCond_t cond
);

   opcode_t     opcode;
   instrClass_t instrClass;
   linkShadow_t linkShadow;
   logic        shadowBusy;

   // Major opcode sits in the top five instruction bits
   assign opcode = instr[15:11];

   // Classify the instruction in decode
   // Jump-and-link forms are exact matches while branches share a 3-bit prefix
   always_comb begin
      instrClass = OTHER;
      if (opcode == OP_JAL) begin
         instrClass = JAL;
      end else if (opcode == OP_JALR) begin
         instrClass = JALR;
      end else if (opcode[4:2] == OP_BRANCH_HI) begin
         instrClass = BRANCH;
      end
   end

   assign isBranch = (instrClass == BRANCH);
   assign isLink   = (instrClass == JAL) || (instrClass == JALR);

   // The low two opcode bits select the branch test and only matter for branches
   assign cond = branchCond_t'(instr[12:11]);

   // Rs and Rt fields feed the two read ports directly
   assign regs.readAddr1 = instr[10:8];
   assign regs.readAddr2 = instr[7:5];

   // Shift a marker along for every jump-and-link leaving decode
   // A link seen in cycle n occupies bit 0 in n+1 and the top bit in n+3
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         linkShadow <= '0;
      end else begin
         linkShadow <= {linkShadow[`LINK_DEPTH-2:0], isLink};
      end
   end

   // Any link still in flight means the writeback result belongs to a slot
   // whose write was already done early from decode
   assign shadowBusy = |linkShadow;

   // A jump-and-link in decode takes the write port this cycle and writes r7
   // Otherwise writeback gets the port unless a link is still in flight
   always_comb begin
      if (isLink) begin
         regs.writeEn   = 1'b1;
         regs.writeAddr = LINK_REG;
      end else begin
         regs.writeEn   = wbEn && !shadowBusy;
         regs.writeAddr = wbAddr;
      end
   end

endmodule

// File: hdl/registerFile.sv
// Architectural register file
// REG_COUNT words, two combinational read ports and one clocked write port
`timescale 1ns/10ps
`include "decode_config.svh"

module registerFile import isaPkg::*; (
   input logic    clk,
   input logic    arstN,
   regPortIf.file regs
);

   // Storage for every general register, r7 included
   word_t regArray [`REG_COUNT];

   // All registers come out of reset as zero
   // A write becomes visible on the read ports from the next cycle on
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < `REG_COUNT; i++) begin
            regArray[i] <= '0;
         end
      end else if (regs.writeEn) begin
         regArray[regs.writeAddr] <= regs.writeData;
      end
   end

   // Reads are not bypassed, they show the contents as of the last edge
   assign regs.readData1 = regArray[regs.readAddr1];
   assign regs.readData2 = regArray[regs.readAddr2];

endmodule

// File: hdl/writebackSelect.sv
// Register write data selection
// Return address computation and the mux between writeback result,
// load-immediate value and return address
`timescale 1ns/10ps

module writebackSelect import isaPkg::*; (
   input  word_t  pcNow,
   input  word_t  imm,
   input  word_t  writeback,
   input  logic   lbi,
   input  logic   link,
   input  logic   isLink,
   regPortIf.data regs,
   output word_t  linkAddr
);

   // Instructions are one word of two bytes, so the return address is PC+2
   assign linkAddr = pcNow + word_t'(2);

   // A link from writeback or a jump-and-link in decode both write the
   // return address, a load-immediate writes its immediate
   always_comb begin
      if (link || isLink) begin
         regs.writeData = linkAddr;
      end else if (lbi) begin
         regs.writeData = imm;
      end else begin
         regs.writeData = writeback;
      end
   end

endmodule

// File: hdl/branchResolve.sv
// Conditional branch resolution
// Zero and sign tests on the first source register, the condition mux
// and the fetch redirect select
`timescale 1ns/10ps
`include "decode_config.svh"

module branchResolve import isaPkg::*; (
   input  word_t       src,
   input  branchCond_t cond,
   input  logic        isBranch,
   input  logic        bFlag,
   input  logic        jFlag,
   input  logic        halt,
   output logic        pcSel
);

   logic isZero;
   logic isNeg;
   logic condMet;

   // Flags of the value in Rs, treated as two's complement
   assign isZero = (src == '0);
   assign isNeg  = src[`DATA_WIDTH-1];

   // Each condition is a single zero or sign test
   always_comb begin
      case (cond)
         BEQZ:    condMet = isZero;
         BNEZ:    condMet = !isZero;
         BLTZ:    condMet = isNeg;
         BGEZ:    condMet = !isNeg;
         default: condMet = 1'b0;
      endcase
   end

   // Redirect fetch for a taken branch or a forced jump
   // An external bFlag marks a branch-like instruction the decoder does not see
   // Halt always wins and keeps fetch on its current path
   assign pcSel = !halt && (isBranch || bFlag) && (condMet || jFlag);

endmodule

// File: hdl/decodeStage.sv
// Decode stage top level
// Plain-port wrapper around the register port bundle, decode control,
// register file, write data selector and branch resolution
`timescale 1ns/10ps

module decodeStage import isaPkg::*; (
   input  logic     clk,
   input  logic     arstN,
   input  word_t    instr,
   input  word_t    imm,
   input  word_t    writeback,
   input  word_t    pcNow,
   input  regAddr_t wbAddr,
   input  logic     wbEn,
   input  logic     lbi,
   input  logic     link,
   input  logic     bFlag,
   input  logic     jFlag,
   input  logic     halt,
   output word_t    reg1Data,
   output word_t    reg2Data,
   output word_t    linkAddr,
   output logic     pcSel
);

   logic        isBranch;
   logic        isLink;
   branchCond_t cond;

   // Shared read and write ports of the register file
   regPortIf regs ();

   decodeControl decodeControl_inst (
      .clk      (clk),
      .arstN    (arstN),
      .instr    (instr),
      .wbEn     (wbEn),
      .wbAddr   (wbAddr),
      .regs     (regs.ctrl),
      .isBranch (isBranch),
      .isLink   (isLink),
      .cond     (cond)
   );

   registerFile registerFile_inst (
      .clk   (clk),
      .arstN (arstN),
      .regs  (regs.file)
   );

   writebackSelect writebackSelect_inst (
      .pcNow     (pcNow),
      .imm       (imm),
      .writeback (writeback),
      .lbi       (lbi),
      .link      (link),
      .isLink    (isLink),
      .regs      (regs.data),
      .linkAddr  (linkAddr)
   );

   // Branches test Rs, which is always read through port 1
   branchResolve branchResolve_inst (
      .src      (regs.readData1),
      .cond     (cond),
      .isBranch (isBranch),
      .bFlag    (bFlag),
      .jFlag    (jFlag),
      .halt     (halt),
      .pcSel    (pcSel)
   );

   assign reg1Data = regs.readData1;
   assign reg2Data = regs.readData2;

endmodule

// File: tests/tbDecodeStage.sv
// Self-checking testbench for the decode stage
// Clock and reset, phased random stimulus, a reference model of the
// register array and the link shadow, and a process that compares outputs
`timescale 1ns/10ps
`include "decode_config.svh"

module tbDecodeStage import isaPkg::*; ();

   localparam int CLK_PERIOD   = 20;
   localparam int DRIVE_DELAY  = 2;
   localparam int CHECK_DELAY  = CLK_PERIOD - 3;
   localparam int RESET_CYCLES = 5;

   // Test phase lengths in cycles add up to the timeout limit
   localparam int READ_CYCLES   = `REG_COUNT;
   localparam int WRITE_CYCLES  = 60;
   localparam int SELECT_CYCLES = 40;
   localparam int LINK_ROUNDS   = 8;
   localparam int LINK_CYCLES   = LINK_ROUNDS * 6 + 5;
   localparam int SEED_CYCLES   = 4;
   localparam int BRANCH_CYCLES = 4 * 24 + 2 * 16;
   localparam int TOTAL_CYCLES  = RESET_CYCLES + READ_CYCLES + WRITE_CYCLES
                                + SELECT_CYCLES + LINK_CYCLES + SEED_CYCLES
                                + BRANCH_CYCLES + 2;
   localparam int CYCLE_LIMIT   = TOTAL_CYCLES + 50;

   // Expected values of the four observable outputs in one cycle
   typedef struct packed {
      word_t reg1;
      word_t reg2;
      word_t link;
      logic  pcSel;
   } expected_t;

   logic     clk;
   logic     arstN;
   word_t    instr;
   word_t    imm;
   word_t    writeback;
   word_t    pcNow;
   regAddr_t wbAddr;
   logic     wbEn;
   logic     lbi;
   logic     link;
   logic     bFlag;
   logic     jFlag;
   logic     halt;
   word_t    reg1Data;
   word_t    reg2Data;
   word_t    linkAddr;
   logic     pcSel;

   // Model of the register array and the link shadow as of the last clock edge
   word_t                  modelRegs [`REG_COUNT];
   logic [`LINK_DEPTH-1:0] modelShadow;
   expected_t              expectNow;
   int                     cycleCount = 0;

   decodeStage decodeStage_inst (
      .clk       (clk),
      .arstN     (arstN),
      .instr     (instr),
      .imm       (imm),
      .writeback (writeback),
      .pcNow     (pcNow),
      .wbAddr    (wbAddr),
      .wbEn      (wbEn),
      .lbi       (lbi),
      .link      (link),
      .bFlag     (bFlag),
      .jFlag     (jFlag),
      .halt      (halt),
      .reg1Data  (reg1Data),
      .reg2Data  (reg2Data),
      .linkAddr  (linkAddr),
      .pcSel     (pcSel)
   );

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic failRun(string reason);
      $display("%s", reason);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped at the first error");
   endtask

   // Opcodes 00110 and 00111 are the two jump-and-link forms
   function automatic logic isLinkOp(word_t word);
      return (word[15:11] == 5'b00110) || (word[15:11] == 5'b00111);
   endfunction

   // Outputs derived from the ISA rules, the model registers and the inputs
   function automatic expected_t referenceOutputs(word_t word, word_t pc, logic bF,
                                                  logic jF, logic h);
      expected_t result;
      word_t     src;
      logic      holds;
      logic      branchOp;
      src      = modelRegs[word[10:8]];
      branchOp = (word[15:13] == 3'b011);
      case (branchCond_t'(word[12:11]))
         BEQZ:    holds = (src == '0);
         BNEZ:    holds = (src != '0);
         BLTZ:    holds = src[`DATA_WIDTH-1];
         BGEZ:    holds = !src[`DATA_WIDTH-1];
         default: holds = 1'b0;
      endcase
      result.reg1  = src;
      result.reg2  = modelRegs[word[7:5]];
      result.link  = pc + word_t'(2);
      result.pcSel = !h && (branchOp || bF) && (holds || jF);
      return result;
   endfunction

   task automatic clearModel();
      for (int i = 0; i < `REG_COUNT; i++) begin
         modelRegs[i] = '0;
      end
      modelShadow = '0;
   endtask

   // Apply the write rules for the coming edge and shift the shadow
   // Strobes in a link cycle or while a link is in flight are dropped
   task automatic updateModel();
      word_t wdata;
      if (isLinkOp(instr)) begin
         modelRegs[`REG_COUNT-1] = pcNow + word_t'(2);
      end else if (wbEn && modelShadow == '0) begin
         if (link) begin
            wdata = pcNow + word_t'(2);
         end else if (lbi) begin
            wdata = imm;
         end else begin
            wdata = writeback;
         end
         modelRegs[wbAddr] = wdata;
      end
      modelShadow = {modelShadow[`LINK_DEPTH-2:0], isLinkOp(instr)};
   endtask

   task automatic checkWord(string name, word_t got, word_t want);
      assert (got === want) else failRun($sformatf("mismatch at %0t: %s is %h, expected %h",
                                                   $time, name, got, want));
   endtask

   // Outputs are compared late in the cycle when the inputs have long settled
   always begin
      @(posedge clk);
      #(CHECK_DELAY);
      if (!arstN) begin
         clearModel();
      end else begin
         expectNow = referenceOutputs(instr, pcNow, bFlag, jFlag, halt);
         checkWord("reg1Data", reg1Data, expectNow.reg1);
         checkWord("reg2Data", reg2Data, expectNow.reg2);
         checkWord("linkAddr", linkAddr, expectNow.link);
         assert (pcSel === expectNow.pcSel) else failRun(
            $sformatf("mismatch at %0t: pcSel is %b, expected %b",
                      $time, pcSel, expectNow.pcSel));
         updateModel();
      end
   end

   always @(posedge clk) begin
      cycleCount++;
      if (cycleCount > CYCLE_LIMIT) begin
         failRun($sformatf("timeout, the test phases did not end within %0d cycles",
                           CYCLE_LIMIT));
      end
   end

   // Any opcode that is neither a branch nor a jump-and-link
   function automatic opcode_t plainOpcode();
      opcode_t op;
      op = opcode_t'($urandom);
      while (op == 5'b00110 || op == 5'b00111 || op[4:2] == 3'b011) begin
         op = opcode_t'($urandom);
      end
      return op;
   endfunction

   function automatic word_t makeInstr(opcode_t op, regAddr_t rs, regAddr_t rt);
      logic [4:0] low;
      low = 5'($urandom);
      return {op, rs, rt, low};
   endfunction

   task automatic stepClock();
      @(posedge clk);
      #(DRIVE_DELAY);
   endtask

   // Idle values for one cycle that each phase partly overrides
   task automatic driveDefaults();
      instr     = makeInstr(plainOpcode(), regAddr_t'($urandom), regAddr_t'($urandom));
      imm       = word_t'($urandom);
      writeback = word_t'($urandom);
      pcNow     = word_t'($urandom);
      wbAddr    = regAddr_t'($urandom);
      wbEn      = 1'b0;
      lbi       = 1'b0;
      link      = 1'b0;
      bFlag     = 1'b0;
      jFlag     = 1'b0;
      halt      = 1'b0;
   endtask

   task automatic strobeWrite(regAddr_t addr, word_t value);
      stepClock();
      driveDefaults();
      wbEn      = 1'b1;
      wbAddr    = addr;
      writeback = value;
   endtask

   initial begin
      arstN = 1'b0;
      instr = '0;
      imm = '0;
      writeback = '0;
      pcNow = '0;
      wbAddr = '0;
      wbEn = 1'b0;
      lbi = 1'b0;
      link = 1'b0;
      bFlag = 1'b0;
      jFlag = 1'b0;
      halt = 1'b0;
      void'($urandom(32'h320e));
      repeat (RESET_CYCLES) @(posedge clk);
      #(DRIVE_DELAY);
      arstN = 1'b1;
      // Every register reads zero on both ports after reset
      for (int i = 0; i < READ_CYCLES; i++) begin
         stepClock();
         driveDefaults();
         instr = makeInstr(plainOpcode(), regAddr_t'(i), regAddr_t'(`REG_COUNT - 1 - i));
      end
      // Random writeback writes where roughly three cycles in four carry a strobe
      for (int i = 0; i < WRITE_CYCLES; i++) begin
         stepClock();
         driveDefaults();
         wbEn = ($urandom_range(0, 3) != 0);
      end
      // Immediate and return address as write data
      for (int i = 0; i < SELECT_CYCLES; i++) begin
         stepClock();
         driveDefaults();
         wbEn = ($urandom_range(0, 4) != 0);
         lbi  = ($urandom_range(0, 1) == 1);
         link = ($urandom_range(0, 2) == 0);
      end
      // Each link is followed by three blocked strobes and two that land
      for (int r = 0; r < LINK_ROUNDS; r++) begin
         stepClock();
         driveDefaults();
         instr = makeInstr(opcode_t'((r % 2 == 0) ? 5'b00110 : 5'b00111),
                           regAddr_t'($urandom), regAddr_t'($urandom));
         wbEn  = 1'b1;
         for (int k = 0; k < 5; k++) begin
            stepClock();
            driveDefaults();
            wbEn = 1'b1;
            lbi  = ($urandom_range(0, 1) == 1);
         end
      end
      // Back-to-back links extend the blocking window
      for (int k = 0; k < 2; k++) begin
         stepClock();
         driveDefaults();
         instr = makeInstr(opcode_t'(5'b00110), regAddr_t'($urandom), regAddr_t'($urandom));
         wbEn  = 1'b1;
      end
      for (int k = 0; k < 3; k++) begin
         stepClock();
         driveDefaults();
         wbEn = 1'b1;
      end
      // Zero, negative and positive sources for the branch tests
      strobeWrite(regAddr_t'(1), '0);
      strobeWrite(regAddr_t'(2), 16'h8000);
      strobeWrite(regAddr_t'(3), 16'h1234);
      strobeWrite(regAddr_t'(4), word_t'($urandom) | 16'h8000);
      for (int c = 0; c < 4; c++) begin
         for (int i = 0; i < 24; i++) begin
            stepClock();
            driveDefaults();
            instr = makeInstr(opcode_t'({3'b011, c[1:0]}), regAddr_t'($urandom),
                              regAddr_t'($urandom));
            jFlag = ($urandom_range(0, 3) == 0);
            halt  = ($urandom_range(0, 3) == 0);
         end
      end
      // Non-branch opcodes run first without and then with bFlag
      for (int i = 0; i < 32; i++) begin
         stepClock();
         driveDefaults();
         bFlag = (i >= 16);
         jFlag = ($urandom_range(0, 2) == 0);
         halt  = ($urandom_range(0, 3) == 0);
      end
      stepClock();
      driveDefaults();
      @(posedge clk);
      $display("TEST PASSED");
      $finish;
   end

endmodule

// File: vlog.f
+incdir+hdl
hdl/isaPkg.sv
hdl/decodePkg.sv
hdl/regPortIf.sv
hdl/decodeControl.sv
hdl/registerFile.sv
hdl/writebackSelect.sv
hdl/branchResolve.sv
hdl/decodeStage.sv
tests/tbDecodeStage.sv

// File: Makefile
# Verilator build and run of the decode stage testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/10ps -j 0
TOP       = tbDecodeStage
FILELIST  = vlog.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "Simulation failed"; \
		exit 1; \
	elif ! grep -q "TEST PASSED" $(LOG); then \
		echo "Simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
